//--- Bender.yml
package:
  name: tart_corr

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tart_sample_pkg.sv
      - hdl/tart_bus_pkg.sv
      - hdl/tart_capture.sv
      - hdl/tart_correlator.sv
      - hdl/tart_control.sv
      - hdl/tart_readout.sv
      - hdl/tart_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/tart_clkgen.sv
      - sim/tart_props.sv
      - sim/tart_tb.sv

//--- hdl/tart_bus_pkg.sv
`include "tart_params.svh"

package tart_bus_pkg;

   // host register map
   typedef enum logic [`TART_ADDR_W-1:0] {
      REG_CTRL   = 4'd0,   // [0] enable, [1] debug
      REG_DELAY  = 4'd1,   // strobe phase 0 .. 5
      REG_BLOCK  = 4'd2,   // samples per block
      REG_STATUS = 4'd3,   // [0] ready [1] ovf [2] enable [3] debug
      REG_VIS0   = 4'd8    // pair p lives at 8+p
   } reg_addr_e;

   // host strobe port, one access per cycle at most
   typedef struct packed {
      logic                    wr;
      logic                    rd;
      logic [`TART_ADDR_W-1:0] addr;
      logic [`TART_DATA_W-1:0] wdata;
   } host_cmd_t;

   // live configuration as seen by the datapath
   typedef struct packed {
      logic                     enable;     // run capture
      logic                     debug;      // fake source instead of antennas
      logic [`TART_PHASE_W-1:0] delay;      // phase of the sample strobe
      logic [`TART_BLK_W-1:0]   block_len;  // never 0
   } cfg_t;

endpackage

//--- hdl/tart_capture.sv
`timescale 1ns/1ps
`include "tart_params.svh"

module tart_capture import tart_sample_pkg::*, tart_bus_pkg::*; (
   input  logic                     fpga_clk,
   input  logic                     rst_n_i,
   input  cfg_t                     cfg_i,
   input  logic [`TART_NUM_ANT-1:0] antenna_i,
   output sample_t                  smp_o
);

   cap_state_e               state_q;
   logic [`TART_NUM_ANT-1:0] ant_q;      // io register
   logic [`TART_PHASE_W-1:0] phase_q;    // position inside the sample period
   logic [`TART_NUM_ANT-1:0] fake_q;     // debug counter source
   logic [`TART_BLK_W-1:0]   blk_cnt_q;  // strobes already in this block
   logic                     strobe;
   logic                     blk_end;

   // antenna pads straight into flops
   always_ff @(posedge fpga_clk) begin
      ant_q <= antenna_i;
   end

   // --------------------------------------------------
   // run control follows the enable bit
   // --------------------------------------------------
   always_ff @(posedge fpga_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= CAP_IDLE;
      end else begin
         case (state_q)
            CAP_IDLE: begin
               if (cfg_i.enable) state_q <= CAP_RUN;
            end
            default: begin
               if (!cfg_i.enable) state_q <= CAP_IDLE;
            end
         endcase
      end
   end

   // --------------------------------------------------
   // phase, fake and block counters
   // --------------------------------------------------
   always_ff @(posedge fpga_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_q   <= '0;
         fake_q    <= '0;
         blk_cnt_q <= '0;
      end else if (state_q == CAP_IDLE) begin
         // held at zero, so RUN always starts clean
         phase_q   <= '0;
         fake_q    <= '0;
         blk_cnt_q <= '0;
      end else begin
         if (phase_q == `TART_PHASE_W'(`TART_DECIM - 1)) phase_q <= '0;
         else phase_q <= phase_q + 1'b1;
         if (strobe) begin
            fake_q    <= fake_q + 1'b1;                       // next fake word
            blk_cnt_q <= blk_end ? '0 : blk_cnt_q + 1'b1;     // restart on last
         end
      end
   end

   assign strobe  = (state_q == CAP_RUN) && cfg_i.enable && (phase_q == cfg_i.delay);
   // >= so a shortened block_len still closes the block
   assign blk_end = ({1'b0, blk_cnt_q} + 1'b1) >= {1'b0, cfg_i.block_len};

   // last while idle flushes partial sums downstream
   always_comb begin
      smp_o.valid = strobe;
      smp_o.bits  = cfg_i.debug ? fake_q : ant_q;
      smp_o.last  = (state_q == CAP_IDLE) || (strobe && blk_end);
   end

endmodule

//--- hdl/tart_control.sv
`timescale 1ns/1ps
`include "tart_params.svh"

module tart_control import tart_bus_pkg::*; (
   input  logic      fpga_clk,
   input  logic      rst_n_i,
   input  host_cmd_t host_cmd_i,
   output cfg_t      cfg_o,
   output logic      ovf_clr_o
);

   cfg_t                     cfg_q;
   logic                     wr_ctrl;
   logic                     wr_delay;
   logic                     wr_block;
   logic                     wr_status;
   logic [`TART_PHASE_W-1:0] delay_lim;   // clamped phase
   logic [`TART_BLK_W-1:0]   block_lim;   // zero-length guarded

   // --------------------------------------------------
   // address decode, writes only
   // --------------------------------------------------
   always_comb begin
      wr_ctrl   = 1'b0;
      wr_delay  = 1'b0;
      wr_block  = 1'b0;
      wr_status = 1'b0;
      if (host_cmd_i.wr) begin
         case (host_cmd_i.addr)
            REG_CTRL:   wr_ctrl   = 1'b1;
            REG_DELAY:  wr_delay  = 1'b1;
            REG_BLOCK:  wr_block  = 1'b1;
            REG_STATUS: wr_status = 1'b1;
            default:    ;                   // vis and holes are read only
         endcase
      end
   end

   // --------------------------------------------------
   // value sanitising
   // --------------------------------------------------
   // phases past the period would never strobe
   always_comb begin
      if (host_cmd_i.wdata > `TART_DATA_W'(`TART_DELAY_MAX)) begin
         delay_lim = `TART_PHASE_W'(`TART_DELAY_MAX);
      end else begin
         delay_lim = host_cmd_i.wdata[`TART_PHASE_W-1:0];
      end
   end

   // a zero block would never close
   assign block_lim = (host_cmd_i.wdata == '0) ? `TART_BLK_W'(1)
                                               : host_cmd_i.wdata[`TART_BLK_W-1:0];

   // --------------------------------------------------
   // configuration registers
   // --------------------------------------------------
   always_ff @(posedge fpga_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg_q.enable    <= 1'b0;
         cfg_q.debug     <= 1'b0;
         cfg_q.delay     <= '0;
         cfg_q.block_len <= `TART_BLK_W'(`TART_BLK_DEFAULT);
      end else begin
         if (wr_ctrl) begin
            cfg_q.enable <= host_cmd_i.wdata[0];
            cfg_q.debug  <= host_cmd_i.wdata[1];
         end
         if (wr_delay) cfg_q.delay     <= delay_lim;
         if (wr_block) cfg_q.block_len <= block_lim;
      end
   end

   assign cfg_o     = cfg_q;
   assign ovf_clr_o = wr_status;   // readout clears on the same edge

endmodule

//--- hdl/tart_correlator.sv
`timescale 1ns/1ps
`include "tart_params.svh"

module tart_correlator import tart_sample_pkg::*; (
   input  logic                   fpga_clk,
   input  logic                   rst_n_i,
   input  sample_t                smp_i,
   input  logic                   ant_a_i,
   input  logic                   ant_b_i,
   output logic [`TART_VIS_W-1:0] vis_o,
   output logic                   done_o
);

   logic [`TART_VIS_W-1:0] acc_q;     // running agreement count
   logic [`TART_VIS_W-1:0] acc_next;
   logic                   agree;     // 1-bit correlation product
   logic                   close;     // final sample of the block

   assign agree    = ~(ant_a_i ^ ant_b_i);
   assign acc_next = acc_q + `TART_VIS_W'(agree);
   assign close    = smp_i.valid && smp_i.last;

   // --------------------------------------------------
   // accumulator
   // --------------------------------------------------
   always_ff @(posedge fpga_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_q <= '0;
      end else if (smp_i.last) begin
         acc_q <= '0;               // block closed, or capture idle
      end else if (smp_i.valid) begin
         acc_q <= acc_next;
      end
   end

   // block result, includes the closing sample
   always_ff @(posedge fpga_clk) begin
      if (close) vis_o <= acc_next;
   end

   // one pulse, same cycle as the fresh vis_o
   always_ff @(posedge fpga_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         done_o <= 1'b0;
      end else begin
         done_o <= close;
      end
   end

endmodule

//--- hdl/tart_params.svh
`ifndef TART_PARAMS_SVH
`define TART_PARAMS_SVH

// --------------------------------------------------
// array geometry
// --------------------------------------------------
`define TART_NUM_ANT      4    // 1-bit antennas on the sample bus
`define TART_NUM_PAIR     6    // 4 choose 2 baselines

// --------------------------------------------------
// sample timing
// --------------------------------------------------
`define TART_DECIM        6    // fpga_clk cycles per sample strobe
`define TART_PHASE_W      3    // holds 0 .. TART_DECIM-1
`define TART_DELAY_MAX    5    // last legal strobe phase

// --------------------------------------------------
// accumulation
// --------------------------------------------------
`define TART_VIS_W        16   // visibility count
`define TART_BLK_W        16   // block length in samples
`define TART_BLK_DEFAULT  64   // block length out of reset

// --------------------------------------------------
// host register port
// --------------------------------------------------
`define TART_ADDR_W       4
`define TART_DATA_W       16

`endif

//--- hdl/tart_readout.sv
`timescale 1ns/1ps
`include "tart_params.svh"

module tart_readout import tart_sample_pkg::*, tart_bus_pkg::*; (
   input  logic                    fpga_clk,
   input  logic                    rst_n_i,
   input  host_cmd_t               host_cmd_i,
   input  cfg_t                    cfg_i,
   input  vis_bank_t               vis_i,
   input  logic                    done_i,     // bank switch
   input  logic                    ovf_clr_i,
   output logic [`TART_DATA_W-1:0] rd_data_o,
   output logic                    rd_valid_o,
   output logic                    ready_o
);

   vis_bank_t               bank_q;    // latched visibilities
   logic                    ready_q;
   logic                    ovf_q;     // sticky, bank was dropped
   logic                    last_rd;   // host read the final pair
   logic                    is_vis;
   logic [`TART_ADDR_W-1:0] vis_idx;
   logic [`TART_DATA_W-1:0] rd_word;

   assign last_rd = host_cmd_i.rd
                    && (host_cmd_i.addr == `TART_ADDR_W'(REG_VIS0 + `TART_NUM_PAIR - 1));
   assign vis_idx = host_cmd_i.addr - REG_VIS0;
   assign is_vis  = (host_cmd_i.addr >= REG_VIS0)
                    && (vis_idx < `TART_ADDR_W'(`TART_NUM_PAIR));

   // --------------------------------------------------
   // bank latch and flags
   // --------------------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (done_i && !ready_q) bank_q <= vis_i;   // unread bank is kept
   end

   always_ff @(posedge fpga_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ready_q <= 1'b0;
         ovf_q   <= 1'b0;
      end else begin
         if (done_i && !ready_q) ready_q <= 1'b1;
         else if (last_rd) ready_q <= 1'b0;
         if (done_i && ready_q) ovf_q <= 1'b1;   // new overflow wins over clear
         else if (ovf_clr_i) ovf_q <= 1'b0;
      end
   end

   // --------------------------------------------------
   // read mux, registered
   // --------------------------------------------------
   always_comb begin
      rd_word = '0;   // holes read as zero
      if (host_cmd_i.addr == REG_STATUS) begin
         rd_word[3:0] = {cfg_i.debug, cfg_i.enable, ovf_q, ready_q};
      end else if (is_vis) begin
         rd_word = bank_q[vis_idx];
      end
   end

   always_ff @(posedge fpga_clk) begin
      if (host_cmd_i.rd) rd_data_o <= rd_word;
   end

   always_ff @(posedge fpga_clk or negedge rst_n_i) begin
      if (!rst_n_i) rd_valid_o <= 1'b0;
      else rd_valid_o <= host_cmd_i.rd;
   end

   assign ready_o = ready_q;

endmodule

//--- hdl/tart_sample_pkg.sv
`include "tart_params.svh"

package tart_sample_pkg;

   // one strobed sample of the whole array
   typedef struct packed {
      logic                     valid;  // one cycle per sample period
      logic [`TART_NUM_ANT-1:0] bits;   // bit i is antenna i
      logic                     last;   // closes the current block
   } sample_t;

   // capture block state
   typedef enum logic {
      CAP_IDLE,
      CAP_RUN
   } cap_state_e;

   // one count per baseline, pair p in slice p
   typedef logic [`TART_NUM_PAIR-1:0][`TART_VIS_W-1:0] vis_bank_t;

   // --------------------------------------------------
   // baseline ordering (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   // --------------------------------------------------
   function automatic int pair_ant_a(input int p);
      case (p)
         0, 1, 2: return 0;
         3, 4:    return 1;
         default: return 2;
      endcase
   endfunction

   function automatic int pair_ant_b(input int p);
      case (p)
         0:       return 1;
         1, 3:    return 2;
         default: return 3;
      endcase
   endfunction

endpackage

//--- hdl/tart_top.sv
`timescale 1ns/1ps
`include "tart_params.svh"

module tart_top import tart_sample_pkg::*, tart_bus_pkg::*; (
   input  logic                     fpga_clk,
   input  logic                     rst_n_i,
   input  logic [`TART_NUM_ANT-1:0] antenna_i,
   input  host_cmd_t                host_cmd_i,
   output logic [`TART_DATA_W-1:0]  rd_data_o,
   output logic                     rd_valid_o,
   output logic                     ready_o
);

   cfg_t                      cfg;       // live configuration
   logic                      ovf_clr;
   sample_t                   smp;       // strobed array sample
   vis_bank_t                 vis;       // one count per baseline
   logic [`TART_NUM_PAIR-1:0] done;      // all pulse together

   // --------------------------------------------------
   // host registers
   // --------------------------------------------------
   tart_control u_control (
      .fpga_clk   (fpga_clk),
      .rst_n_i    (rst_n_i),
      .host_cmd_i (host_cmd_i),
      .cfg_o      (cfg),
      .ovf_clr_o  (ovf_clr)
   );

   // --------------------------------------------------
   // sampling
   // --------------------------------------------------
   tart_capture u_capture (
      .fpga_clk  (fpga_clk),
      .rst_n_i   (rst_n_i),
      .cfg_i     (cfg),
      .antenna_i (antenna_i),
      .smp_o     (smp)
   );

   // one correlator per baseline
   for (genvar p = 0; p < `TART_NUM_PAIR; p++) begin : g_corr
      tart_correlator u_corr (
         .fpga_clk (fpga_clk),
         .rst_n_i  (rst_n_i),
         .smp_i    (smp),
         .ant_a_i  (smp.bits[pair_ant_a(p)]),
         .ant_b_i  (smp.bits[pair_ant_b(p)]),
         .vis_o    (vis[p]),
         .done_o   (done[p])
      );
   end

   // --------------------------------------------------
   // visibility bank and host reads
   // --------------------------------------------------
   tart_readout u_readout (
      .fpga_clk   (fpga_clk),
      .rst_n_i    (rst_n_i),
      .host_cmd_i (host_cmd_i),
      .cfg_i      (cfg),
      .vis_i      (vis),
      .done_i     (done[0]),      // pair 0 stands for all
      .ovf_clr_i  (ovf_clr),
      .rd_data_o  (rd_data_o),
      .rd_valid_o (rd_valid_o),
      .ready_o    (ready_o)
   );

endmodule

//--- sim/tart_clkgen.sv
`timescale 1ns/1ps

module tart_clkgen (
   output logic fpga_clk_o,
   output logic rst_n_o
);

   initial fpga_clk_o = 1'b0;
   always #10 fpga_clk_o = ~fpga_clk_o;   // 20 ns period

   // reset low for 10 cycles, released away from the rising edge
   initial begin
      rst_n_o = 1'b0;
      repeat (10) @(posedge fpga_clk_o);
      @(negedge fpga_clk_o);
      rst_n_o = 1'b1;
   end

endmodule

//--- sim/tart_patterns.txt
// per block: block length, that many antenna words (bit i is antenna i),
// then six counts for pairs (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
0040
0 F 3 C 5 A 6 9 1 E 7 8 F 0 2 D
0 F 3 C 5 A 6 9 1 E 7 8 F 0 2 D
0 F 3 C 5 A 6 9 1 E 7 8 F 0 2 D
F F F F F F F F F F F F F F F F
28 2E 28 2E 28 2E
000A
1 2 4 8 3 6 C 9 0 7
6 4 5 6 3 5

//--- sim/tart_props.sv
`timescale 1ns/1ps
`include "tart_params.svh"

module tart_props import tart_bus_pkg::*; (
   input logic                      fpga_clk,
   input logic                      rst_n_i,
   input host_cmd_t                 host_cmd_i,
   input logic                      rd_valid_i,
   input logic                      smp_valid_i,
   input logic [`TART_NUM_PAIR-1:0] done_i
);

   logic host_en_q;   // enable bit as last written by the host

   // host view of REG_CTRL[0], one edge after the write
   always_ff @(posedge fpga_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         host_en_q <= 1'b0;
      end else if (host_cmd_i.wr && (host_cmd_i.addr == REG_CTRL)) begin
         host_en_q <= host_cmd_i.wdata[0];
      end
   end

   // --------------------------------------------------
   // host read port
   // --------------------------------------------------
   a_rd_latency: assert property (@(posedge fpga_clk) disable iff (!rst_n_i)
      host_cmd_i.rd |=> rd_valid_i)
      else $error("rd_valid_o missing one cycle after a read strobe");

   a_rd_source: assert property (@(posedge fpga_clk) disable iff (!rst_n_i)
      rd_valid_i |-> $past(host_cmd_i.rd))
      else $error("rd_valid_o without a read strobe one cycle earlier");

   // --------------------------------------------------
   // sample path
   // --------------------------------------------------
   a_idle_quiet: assert property (@(posedge fpga_clk) disable iff (!rst_n_i)
      !host_en_q |-> !smp_valid_i)
      else $error("sample strobe while capture is disabled");

   a_done_width: assert property (@(posedge fpga_clk) disable iff (!rst_n_i)
      (|done_i) |=> !(|done_i))
      else $error("correlator done wider than one cycle");

endmodule

bind tart_top tart_props u_props (
   .fpga_clk    (fpga_clk),
   .rst_n_i     (rst_n_i),
   .host_cmd_i  (host_cmd_i),
   .rd_valid_i  (rd_valid_o),
   .smp_valid_i (smp.valid),
   .done_i      (done)
);

//--- sim/tart_tb.sv
`timescale 1ns/1ps
`include "tart_params.svh"

module tart_tb import tart_bus_pkg::*; ();

   logic                     fpga_clk;
   logic                     rst_n_i;
   logic [`TART_NUM_ANT-1:0] antenna_i;
   host_cmd_t                host_cmd;
   logic [`TART_DATA_W-1:0]  rd_data;
   logic                     rd_valid;
   logic                     ready;

   logic [15:0] pat [0:255];                  // patterns file image
   logic [15:0] exp_vis [`TART_NUM_PAIR];     // expected bank
   logic [15:0] word;
   int          ant_a [`TART_NUM_PAIR] = '{0, 0, 0, 1, 1, 2};
   int          ant_b [`TART_NUM_PAIR] = '{1, 2, 3, 2, 3, 3};
   int          ptr;                          // next entry in pat
   int          errors;
   int          tests_failed;
   int          mark;
   int          lat;
   int          n;

   tart_clkgen u_clkgen (
      .fpga_clk_o (fpga_clk),
      .rst_n_o    (rst_n_i)
   );

   tart_top u_tart_top (
      .fpga_clk   (fpga_clk),
      .rst_n_i    (rst_n_i),
      .antenna_i  (antenna_i),
      .host_cmd_i (host_cmd),
      .rd_data_o  (rd_data),
      .rd_valid_o (rd_valid),
      .ready_o    (ready)
   );

   task automatic report_mismatch(input string what, input logic [15:0] got,
                                  input logic [15:0] exp);
      errors++;
      $display("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp);
   endtask

   task automatic report_fault(input string msg);
      errors++;
      $display("at %0t ns: %s", $time, msg);
   endtask

   // one write strobe, driven on the falling edge
   task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
      @(negedge fpga_clk);
      host_cmd.wr    = 1'b1;
      host_cmd.addr  = addr;
      host_cmd.wdata = data;
      @(negedge fpga_clk);
      host_cmd.wr = 1'b0;
   endtask

   // returns the data and how many cycles rd_valid_o took
   task automatic read_reg(input logic [3:0] addr, output logic [15:0] data,
                           output int cycles);
      @(negedge fpga_clk);
      host_cmd.rd   = 1'b1;
      host_cmd.addr = addr;
      cycles        = 0;
      do begin
         @(negedge fpga_clk);
         host_cmd.rd = 1'b0;
         cycles++;
      end while (!rd_valid && cycles < 16);
      if (!rd_valid) report_fault($sformatf("no rd_valid_o after reading address %0d", addr));
      data = rd_data;
   endtask

   task automatic wait_ready(input int limit);
      int cyc;
      cyc = 0;
      while (!ready && cyc < limit) begin
         @(negedge fpga_clk);
         cyc++;
      end
      if (!ready) report_fault("timed out waiting for ready_o");
   endtask

   task automatic check_bank(input string tag);
      logic [15:0] data;
      int          cyc;
      for (int p = 0; p < `TART_NUM_PAIR; p++) begin
         read_reg(4'(REG_VIS0) + 4'(p), data, cyc);
         if (data !== exp_vis[p]) report_mismatch($sformatf("%s vis%0d", tag, p), data, exp_vis[p]);
      end
   endtask

   // --------------------------------------------------
   // stimulus blocks
   // --------------------------------------------------
   task automatic run_file_block(input logic [15:0] delay, input logic set_len);
      int len;
      len = pat[ptr];
      if (set_len) write_reg(REG_BLOCK, 16'(len));
      write_reg(REG_DELAY, delay);
      write_reg(REG_CTRL, 16'h0001);
      for (int i = 0; i < len; i++) begin
         antenna_i = pat[ptr + 1 + i][3:0];
         repeat (`TART_DECIM) @(negedge fpga_clk);   // one full strobe period per word
      end
      for (int p = 0; p < `TART_NUM_PAIR; p++) exp_vis[p] = pat[ptr + 1 + len + p];
      ptr = ptr + len + 1 + `TART_NUM_PAIR;
      wait_ready(64);
      write_reg(REG_CTRL, 16'h0000);
   endtask

   // pair agreement over a 4-bit counter starting at 0
   function automatic logic [15:0] fake_count(input int p, input int len);
      logic [3:0]  v;
      logic [15:0] cnt;
      cnt = '0;
      for (int i = 0; i < len; i++) begin
         v = 4'(i);
         if (v[ant_a[p]] == v[ant_b[p]]) cnt++;
      end
      return cnt;
   endfunction

   task automatic start_debug_block(input int len);
      write_reg(REG_BLOCK, 16'(len));
      write_reg(REG_CTRL, 16'h0003);   // enable + debug
      for (int p = 0; p < `TART_NUM_PAIR; p++) exp_vis[p] = fake_count(p, len);
   endtask

   task automatic end_test(input int num, input string name);
      if (errors == mark) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, errors - mark);
         tests_failed++;
      end
      mark = errors;
   endtask

   initial begin
      antenna_i    = '0;
      host_cmd     = '0;
      errors       = 0;
      tests_failed = 0;
      mark         = 0;
      ptr          = 0;
      $readmemh("sim/tart_patterns.txt", pat);
      n = 0;
      while (rst_n_i !== 1'b1 && n < 100) begin
         @(negedge fpga_clk);
         n++;
      end
      if (rst_n_i !== 1'b1) report_fault("reset was never released");

      // reset state, then the default 64 sample block
      if (ready !== 1'b0) report_mismatch("ready_o after reset", 16'(ready), 16'h0);
      read_reg(REG_STATUS, word, lat);
      if (word !== 16'h0000) report_mismatch("status after reset", word, 16'h0000);
      run_file_block(16'd0, 1'b0);
      check_bank("default block");
      end_test(1, "reset values");

      run_file_block(16'd4, 1'b1);
      check_bank("block 10 delay 4");
      if (ready !== 1'b0) report_mismatch("ready_o after last vis read", 16'(ready), 16'h0);
      end_test(2, "block length and delay");

      start_debug_block(16);
      wait_ready(200);
      write_reg(REG_CTRL, 16'h0000);
      check_bank("debug block");
      end_test(3, "debug source");

      // --------------------------------------------------
      // two blocks land, the second is dropped
      // --------------------------------------------------
      start_debug_block(20);
      wait_ready(200);
      word = '0;
      n    = 0;
      while (!word[1] && n < 100) begin
         read_reg(REG_STATUS, word, lat);
         n++;
      end
      if (word !== 16'h000F) report_mismatch("status with overflow", word, 16'h000F);
      write_reg(REG_CTRL, 16'h0000);
      write_reg(REG_STATUS, 16'h0000);
      read_reg(REG_STATUS, word, lat);
      if (word !== 16'h0001) report_mismatch("status after overflow clear", word, 16'h0001);
      check_bank("kept bank");
      end_test(4, "overflow");

      for (int a = 4; a < 8; a++) begin
         read_reg(4'(a), word, lat);
         if (word !== 16'h0000) report_mismatch($sformatf("address %0d", a), word, 16'h0000);
         if (lat != 1) report_mismatch($sformatf("address %0d latency", a), 16'(lat), 16'h1);
      end
      end_test(5, "read timing");

      $display("tests run: 5, tests failed: %0d, checks failed: %0d", tests_failed, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+hdl
hdl/tart_sample_pkg.sv
hdl/tart_bus_pkg.sv
hdl/tart_capture.sv
hdl/tart_correlator.sv
hdl/tart_control.sv
hdl/tart_readout.sv
hdl/tart_top.sv
sim/tart_clkgen.sv
sim/tart_props.sv
sim/tart_tb.sv
